//--- filelist.f
lsu_pkg.sv
addr_xlate.sv
lsu.sv
dbus_arbiter.sv
data_ram.sv
lsu_top.sv
lsu_properties.sv
tb_lsu.sv

//--- run.sh
#!/bin/bash
# build with Verilator, run, then judge the log
set -o pipefail
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_lsu -f filelist.f -o sim_lsu \
	&& ./obj_dir/sim_lsu 2>&1 | tee sim.log \
	|| { echo "build or simulation failed"; exit 1; }
grep -q "Finished with errors" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }

//--- tb_lsu.sv
`timescale 1ns/1ps

module tb_lsu import lsu_pkg::*; ();

	logic        clk = 1'b0;
	logic        rst_n;
	logic        flush;
	logic        issue;
	mem_op_t     op;
	logic [31:0] base;
	logic [15:0] offset;
	logic [31:0] store_data;
	logic [31:0] rt_old;
	logic        host_req;
	logic        host_we;
	logic [31:0] host_addr;
	logic [3:0]  host_be;
	logic [31:0] host_wdata;
	logic        busy;
	logic        done;
	logic [31:0] load_data;
	logic        exc_valid;
	exc_code_t   exc_code;
	logic [31:0] bad_vaddr;
	logic        host_rvalid;
	logic [31:0] host_rdata;

	int          errors = 0;
	int          checks = 0;
	int          r_lat;
	logic [31:0] r_data;
	logic        r_exc;
	exc_code_t   r_code;
	logic [31:0] r_bad;
	// physical word used by the next lane test
	logic [31:0] next_word = 32'h100;

	lsu_top u_dut (.*);

	always #20 clk = ~clk;

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Error %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic host_write(input logic [31:0] a, input logic [31:0] d);
		host_req   = 1'b1;
		host_we    = 1'b1;
		host_addr  = a;
		host_be    = 4'hf;
		host_wdata = d;
		@(negedge clk);
		host_req = 1'b0;
	endtask

	task automatic host_read(input logic [31:0] a, output logic [31:0] d);
		int   n;
		logic got;
		n         = 0;
		got       = 1'b0;
		d         = 32'hx;
		host_req  = 1'b1;
		host_we   = 1'b0;
		host_addr = a;
		while (!got && n < 10) begin
			@(negedge clk);
			host_req = 1'b0;
			n++;
			if (host_rvalid) begin
				got = 1'b1;
				d   = host_rdata;
			end
		end
		if (!got) begin
			errors++;
			$display("host read of %h got no rvalid", a);
		end
	endtask

	// issue one op; host_at picks the cycle of an optional host write
	task automatic run_op(input mem_op_t o, input logic [31:0] b, input logic [15:0] ofs,
			input logic [31:0] sd, input logic [31:0] rt, input int host_at,
			input logic [31:0] ha, input logic [31:0] hd);
		int   n;
		logic got;
		n          = 0;
		got        = 1'b0;
		op         = o;
		base       = b;
		offset     = ofs;
		store_data = sd;
		rt_old     = rt;
		issue      = 1'b1;
		while (!got && n < 40) begin
			@(negedge clk);
			n++;
			issue      = 1'b0;
			host_req   = (n == host_at);
			host_we    = 1'b1;
			host_addr  = ha;
			host_be    = 4'hf;
			host_wdata = hd;
			if (done) begin
				got    = 1'b1;
				r_lat  = n;
				r_data = load_data;
				r_exc  = exc_valid;
				r_code = exc_code;
				r_bad  = bad_vaddr;
			end
		end
		host_req = 1'b0;
		if (!got) begin
			errors++;
			$display("no done within 40 cycles for %s", o.name());
		end
	endtask

	// little-endian lane rules
	function automatic logic [31:0] model_load(input mem_op_t o, input logic [31:0] w,
			input logic [31:0] rt, input logic [1:0] off);
		logic [31:0] r;
		logic [7:0]  b0;
		logic [15:0] h0;
		b0 = w[8*off +: 8];
		h0 = off[1] ? w[31:16] : w[15:0];
		r  = rt;
		case (o)
			LB:      r = {{24{b0[7]}}, b0};
			LBU:     r = {24'h0, b0};
			LH:      r = {{16{h0[15]}}, h0};
			LHU:     r = {16'h0, h0};
			LW:      r = w;
			LWL:     for (int i = 0; i <= off; i++) r[8*(3-off+i) +: 8] = w[8*i +: 8];
			LWR:     for (int i = off; i < 4; i++) r[8*(i-off) +: 8] = w[8*i +: 8];
			default: ;
		endcase
		return r;
	endfunction

	function automatic logic [31:0] model_store(input mem_op_t o, input logic [31:0] old,
			input logic [31:0] sd, input logic [1:0] off);
		logic [31:0] m;
		m = old;
		case (o)
			SB:      m[8*off +: 8] = sd[7:0];
			SH:      m = off[1] ? {sd[15:0], old[15:0]} : {old[31:16], sd[15:0]};
			SW:      m = sd;
			SWL:     for (int i = 0; i <= off; i++) m[8*i +: 8] = sd[8*(3-off+i) +: 8];
			SWR:     for (int i = off; i < 4; i++) m[8*i +: 8] = sd[8*(i-off) +: 8];
			default: ;
		endcase
		return m;
	endfunction

	// preload a fresh word, access it through kseg0, check data and latency
	task automatic access_check(input mem_op_t o, input logic [1:0] off);
		logic [31:0] word;
		logic [31:0] old;
		logic [31:0] sd;
		logic [31:0] rt;
		logic [31:0] got;
		string       name;
		word      = next_word;
		next_word = next_word + 32'd4;
		old       = $urandom();
		sd        = $urandom();
		rt        = $urandom();
		name      = $sformatf("%s_off%0d", o.name(), off);
		host_write(word, old);
		run_op(o, KSEG0_BASE + word, {14'h0, off}, sd, rt, 0, 32'h0, 32'h0);
		check({name, "_exc"}, 32'd0, {31'd0, r_exc});
		if (o inside {SB, SH, SW, SWL, SWR}) begin
			host_read(word, got);
			check(name, model_store(o, old, sd, off), got);
			check({name, "_latency"}, 32'd4, r_lat);
		end else begin
			check(name, model_load(o, old, rt, off), r_data);
			check({name, "_latency"}, 32'd5, r_lat);
		end
	endtask

	task automatic test_stores();
		for (int k = 0; k < 4; k++)
			access_check(SB, 2'(k));
		access_check(SH, 2'd0);
		access_check(SH, 2'd2);
		access_check(SW, 2'd0);
	endtask

	task automatic test_loads();
		for (int k = 0; k < 4; k++) begin
			access_check(LB, 2'(k));
			access_check(LBU, 2'(k));
		end
		for (int k = 0; k < 4; k += 2) begin
			access_check(LH, 2'(k));
			access_check(LHU, 2'(k));
		end
		access_check(LW, 2'd0);
	endtask

	task automatic test_unaligned();
		for (int k = 0; k < 4; k++) begin
			access_check(LWL, 2'(k));
			access_check(LWR, 2'(k));
			access_check(SWL, 2'(k));
			access_check(SWR, 2'(k));
		end
	endtask

	// base sits 8 above vaddr so the offset is negative
	task automatic exc_case(input mem_op_t o, input logic [31:0] va, input exc_code_t code);
		logic [31:0] word;
		logic [31:0] old;
		logic [31:0] got;
		string       name;
		word = {20'h0, va[11:2], 2'b00};
		old  = $urandom();
		name = $sformatf("%s_%h", o.name(), va);
		host_write(word, old);
		run_op(o, va + 32'd8, 16'hfff8, $urandom(), 32'h0, 0, 32'h0, 32'h0);
		check({name, "_exc"}, 32'd1, {31'd0, r_exc});
		check({name, "_code"}, {27'd0, code}, {27'd0, r_code});
		check({name, "_bad_vaddr"}, va, r_bad);
		check({name, "_latency"}, 32'd3, r_lat);
		host_read(word, got);
		check({name, "_ram"}, old, got);
	endtask

	task automatic test_exceptions();
		exc_case(LW, KSEG0_BASE + 32'h202, EXC_ADEL);
		exc_case(SH, KSEG0_BASE + 32'h305, EXC_ADES);
		exc_case(SW, KSEG2_BASE + 32'h340, EXC_ADES);
		exc_case(LB, KSEG2_BASE + 32'h350, EXC_ADEL);
		exc_case(SW, 32'h0000_1380, EXC_TLBS);
		exc_case(LW, 32'h0000_2390, EXC_TLBL);
		exc_case(SW, 32'h0000_03a0, EXC_MOD);
	endtask

	task automatic test_contention();
		logic [31:0] sd;
		logic [31:0] hd;
		logic [31:0] got;
		sd = $urandom();
		hd = $urandom();
		host_write(32'h600, $urandom());
		// host write lands while the store waits for its grant
		run_op(SW, KSEG0_BASE + 32'h600, 16'h0, sd, 32'h0, 3, 32'h604, hd);
		check("contention_store_delayed", 32'd1, {31'd0, r_lat > 4});
		host_read(32'h600, got);
		check("contention_store", sd, got);
		host_read(32'h604, got);
		check("contention_host_write0", hd, got);
		hd = $urandom();
		// this one hits the read return window instead
		run_op(LW, KSEG0_BASE + 32'h600, 16'h0, 32'h0, 32'h0, 4, 32'h608, hd);
		check("contention_load", sd, r_data);
		host_read(32'h608, got);
		check("contention_host_write1", hd, got);
	endtask

	task automatic test_flush();
		logic [31:0] w;
		logic        seen;
		w    = $urandom();
		seen = 1'b0;
		host_write(32'h700, w);
		op     = LW;
		base   = KSEG0_BASE + 32'h700;
		offset = 16'h0;
		issue  = 1'b1;
		// grant lands at cycle 4, flush while the read is in flight
		for (int n = 1; n <= 10; n++) begin
			@(negedge clk);
			issue = 1'b0;
			flush = (n == 4);
			if (done)
				seen = 1'b1;
		end
		flush = 1'b0;
		check("flush_no_done", 32'd0, {31'd0, seen});
		check("flush_idle", 32'd0, {31'd0, busy});
		run_op(LW, KSEG0_BASE + 32'h700, 16'h0, 32'h0, 32'h0, 0, 32'h0, 32'h0);
		check("after_flush_load", w, r_data);
		check("after_flush_latency", 32'd5, r_lat);
	endtask

	initial begin
		void'($urandom(32'h209d01fc));
		rst_n      = 1'b0;
		flush      = 1'b0;
		issue      = 1'b0;
		op         = LW;
		base       = 32'h0;
		offset     = 16'h0;
		store_data = 32'h0;
		rt_old     = 32'h0;
		host_req   = 1'b0;
		host_we    = 1'b0;
		host_addr  = 32'h0;
		host_be    = 4'h0;
		host_wdata = 32'h0;
		repeat (5) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		check("reset_busy", 32'd0, {31'd0, busy});
		check("reset_done", 32'd0, {31'd0, done});
		check("reset_exc_valid", 32'd0, {31'd0, exc_valid});
		check("reset_host_rvalid", 32'd0, {31'd0, host_rvalid});
		test_stores();
		test_loads();
		test_unaligned();
		test_exceptions();
		test_contention();
		test_flush();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

//--- lsu_properties.sv
`timescale 1ns/1ps

module lsu_properties (
	input logic clk,
	input logic rst_n,
	input logic flush,
	input logic issue,
	input logic busy,
	input logic done,
	input logic exc_valid,
	input logic lsu_req,
	input logic lsu_gnt
);

	a_no_issue_busy: assert property (@(posedge clk) disable iff (!rst_n)
		issue |-> !busy)
		else $error("issue while the lsu is busy");

	a_done_single: assert property (@(posedge clk) disable iff (!rst_n)
		done |=> !done)
		else $error("done high on two cycles in a row");

	a_exc_with_done: assert property (@(posedge clk) disable iff (!rst_n)
		exc_valid |-> done)
		else $error("exc_valid without done");

	// only a flush may drop a waiting request
	a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
		(lsu_req && !lsu_gnt && !flush) |=> lsu_req)
		else $error("lsu request dropped before grant");

endmodule

bind lsu_top lsu_properties u_props (
	.clk       (clk),
	.rst_n     (rst_n),
	.flush     (flush),
	.issue     (issue),
	.busy      (busy),
	.done      (done),
	.exc_valid (exc_valid),
	.lsu_req   (lsu_req),
	.lsu_gnt   (lsu_gnt)
);

//--- lsu_top.sv
`timescale 1ns/1ps

module lsu_top import lsu_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        flush,
	input  logic        issue,
	input  mem_op_t     op,
	input  logic [31:0] base,
	input  logic [15:0] offset,
	input  logic [31:0] store_data,
	input  logic [31:0] rt_old,
	input  logic        host_req,
	input  logic        host_we,
	input  logic [31:0] host_addr,
	input  logic [3:0]  host_be,
	input  logic [31:0] host_wdata,
	output logic        busy,
	output logic        done,
	output logic [31:0] load_data,
	output logic        exc_valid,
	output exc_code_t   exc_code,
	output logic [31:0] bad_vaddr,
	output logic        host_rvalid,
	output logic [31:0] host_rdata
);

	logic              xlate_req;
	logic [31:0]       vaddr;
	logic              is_store;
	logic              xlate_ready;
	logic [31:0]       paddr;
	logic              illegal;
	logic              miss;
	logic              read_only;
	logic              lsu_req;
	logic              lsu_we;
	logic [31:0]       lsu_addr;
	logic [3:0]        lsu_be;
	logic [31:0]       lsu_wdata;
	logic              lsu_gnt;
	logic              lsu_rvalid;
	logic [31:0]       lsu_rdata;
	logic              ram_en;
	logic              ram_we;
	logic [RAM_AW-1:0] ram_idx;
	logic [3:0]        ram_be;
	logic [31:0]       ram_wdata;
	logic [31:0]       ram_rdata;

	lsu u_lsu (
		.*,
		.req    (lsu_req),
		.we     (lsu_we),
		.addr   (lsu_addr),
		.be     (lsu_be),
		.wdata  (lsu_wdata),
		.gnt    (lsu_gnt),
		.rvalid (lsu_rvalid),
		.rdata  (lsu_rdata)
	);

	// no cache behind the translator
	addr_xlate u_xlate (
		.*,
		.uncached ()
	);

	dbus_arbiter u_arb (.*);

	data_ram u_ram (.*);

endmodule

//--- data_ram.sv
`timescale 1ns/1ps

module data_ram import lsu_pkg::*; (
	input  logic              clk,
	input  logic              ram_en,
	input  logic              ram_we,
	input  logic [RAM_AW-1:0] ram_idx,
	input  logic [3:0]        ram_be,
	input  logic [31:0]       ram_wdata,
	output logic [31:0]       ram_rdata
);

	logic [31:0] mem [RAM_WORDS];
	logic [31:0] rd_pipe [RAM_LATENCY];

	// byte lane writes
	always_ff @(posedge clk) begin
		if (ram_en && ram_we) begin
			for (int b = 0; b < 4; b++) begin
				if (ram_be[b])
					mem[ram_idx][8*b +: 8] <= ram_wdata[8*b +: 8];
			end
		end
	end

	// array read, then output register stages
	always_ff @(posedge clk) begin
		if (ram_en && !ram_we)
			rd_pipe[0] <= mem[ram_idx];
		for (int s = 1; s < RAM_LATENCY; s++) begin
			rd_pipe[s] <= rd_pipe[s-1];
		end
	end

	assign ram_rdata = rd_pipe[RAM_LATENCY-1];

endmodule

//--- dbus_arbiter.sv
`timescale 1ns/1ps

module dbus_arbiter import lsu_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,
	// host master
	input  logic              host_req,
	input  logic              host_we,
	input  logic [31:0]       host_addr,
	input  logic [3:0]        host_be,
	input  logic [31:0]       host_wdata,
	output logic              host_rvalid,
	output logic [31:0]       host_rdata,
	// lsu master
	input  logic              lsu_req,
	input  logic              lsu_we,
	input  logic [31:0]       lsu_addr,
	input  logic [3:0]        lsu_be,
	input  logic [31:0]       lsu_wdata,
	output logic              lsu_gnt,
	output logic              lsu_rvalid,
	output logic [31:0]       lsu_rdata,
	// ram side
	output logic              ram_en,
	output logic              ram_we,
	output logic [RAM_AW-1:0] ram_idx,
	output logic [3:0]        ram_be,
	output logic [31:0]       ram_wdata,
	input  logic [31:0]       ram_rdata
);

	logic [RAM_LATENCY-1:0] rd_pend;
	logic [RAM_LATENCY-1:0] rd_host;

	// host always wins
	assign lsu_gnt   = lsu_req & ~host_req;
	assign ram_en    = host_req | lsu_req;
	assign ram_we    = host_req ? host_we : lsu_we;
	assign ram_idx   = host_req ? host_addr[RAM_AW+1:2] : lsu_addr[RAM_AW+1:2];
	assign ram_be    = host_req ? host_be : lsu_be;
	assign ram_wdata = host_req ? host_wdata : lsu_wdata;

	// owner of each read in flight
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_pend <= '0;
			rd_host <= '0;
		end else begin
			rd_pend <= {rd_pend[RAM_LATENCY-2:0], ram_en & ~ram_we};
			rd_host <= {rd_host[RAM_LATENCY-2:0], host_req};
		end
	end

	assign host_rvalid = rd_pend[RAM_LATENCY-1] & rd_host[RAM_LATENCY-1];
	assign lsu_rvalid  = rd_pend[RAM_LATENCY-1] & ~rd_host[RAM_LATENCY-1];
	assign host_rdata  = host_rvalid ? ram_rdata : 32'h0;
	assign lsu_rdata   = lsu_rvalid ? ram_rdata : 32'h0;

endmodule

//--- lsu.sv
`timescale 1ns/1ps

module lsu import lsu_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        flush,
	// issue
	input  logic        issue,
	input  mem_op_t     op,
	input  logic [31:0] base,
	input  logic [15:0] offset,
	input  logic [31:0] store_data,
	input  logic [31:0] rt_old,
	output logic        busy,
	// translation
	output logic        xlate_req,
	output logic [31:0] vaddr,
	output logic        is_store,
	input  logic        xlate_ready,
	input  logic [31:0] paddr,
	input  logic        illegal,
	input  logic        miss,
	input  logic        read_only,
	// data bus
	output logic        req,
	output logic        we,
	output logic [31:0] addr,
	output logic [3:0]  be,
	output logic [31:0] wdata,
	input  logic        gnt,
	input  logic        rvalid,
	input  logic [31:0] rdata,
	// result
	output logic        done,
	output logic [31:0] load_data,
	output logic        exc_valid,
	output exc_code_t   exc_code,
	output logic [31:0] bad_vaddr
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_XLATE,
		S_BUS,
		S_DATA
	} state_t;

	state_t                 state;
	mem_op_t                op_q;
	logic [31:0]            vaddr_q;
	logic [31:0]            store_data_q;
	logic [31:0]            rt_old_q;
	logic [31:0]            paddr_q;
	logic                   xlate_req_q;
	logic                   done_q;
	logic                   exc_valid_q;
	exc_code_t              exc_code_q;
	exc_code_t              exc_n;
	logic [RAM_LATENCY-1:0] live;
	logic                   accept;
	logic                   misaligned;
	logic                   ret_ok;
	logic [1:0]             off;
	logic [31:0]            rd_shr;
	logic [31:0]            rd_shl;
	logic [3:0]             merge_be;
	logic [31:0]            lane_mask;

	assign accept    = issue && (state == S_IDLE);
	assign off       = vaddr_q[1:0];
	assign is_store  = op_q inside {SB, SH, SW, SWL, SWR};
	assign busy      = (state != S_IDLE);
	assign xlate_req = xlate_req_q;
	assign vaddr     = vaddr_q;
	assign bad_vaddr = vaddr_q;

	assign req  = (state == S_BUS);
	assign we   = is_store;
	assign addr = paddr_q;

	// a return only counts if its grant came after the last flush
	assign ret_ok    = (state == S_DATA) && rvalid && live[RAM_LATENCY-1] && !flush;
	assign done      = done_q | ret_ok;
	assign exc_valid = exc_valid_q;
	assign exc_code  = exc_code_q;

	// address error, then miss, then write to read-only
	always_comb begin
		case (op_q)
			LW, SW:      misaligned = |off;
			LH, LHU, SH: misaligned = off[0];
			default:     misaligned = 1'b0;
		endcase
		if (illegal || misaligned)
			exc_n = is_store ? EXC_ADES : EXC_ADEL;
		else if (miss)
			exc_n = is_store ? EXC_TLBS : EXC_TLBL;
		else if (is_store && read_only)
			exc_n = EXC_MOD;
		else
			exc_n = EXC_NONE;
	end

	// write lanes
	always_comb begin
		be    = 4'b1111;
		wdata = store_data_q;
		case (op_q)
			LB, LBU, SB: begin
				be    = 4'b0001 << off;
				wdata = store_data_q << {off, 3'b000};
			end
			LH, LHU, SH: begin
				be    = off[1] ? 4'b1100 : 4'b0011;
				wdata = off[1] ? {store_data_q[15:0], 16'h0000} : store_data_q;
			end
			SWL: begin
				be    = 4'b1111 >> ~off;
				wdata = store_data_q >> {~off, 3'b000};
			end
			SWR: begin
				be    = 4'b1111 << off;
				wdata = store_data_q << {off, 3'b000};
			end
			default: ;
		endcase
	end

	// read formatting
	assign rd_shr    = rdata >> {off, 3'b000};
	assign rd_shl    = rdata << {~off, 3'b000};
	assign merge_be  = (op_q == LWL) ? (4'b1111 << ~off) : (4'b1111 >> off);
	assign lane_mask = {{8{merge_be[3]}}, {8{merge_be[2]}}, {8{merge_be[1]}}, {8{merge_be[0]}}};

	always_comb begin
		case (op_q)
			LB:      load_data = {{24{rd_shr[7]}}, rd_shr[7:0]};
			LBU:     load_data = {24'h0, rd_shr[7:0]};
			LH:      load_data = {{16{rd_shr[15]}}, rd_shr[15:0]};
			LHU:     load_data = {16'h0, rd_shr[15:0]};
			LWL:     load_data = (rt_old_q & ~lane_mask) | (rd_shl & lane_mask);
			LWR:     load_data = (rt_old_q & ~lane_mask) | (rd_shr & lane_mask);
			default: load_data = rdata;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state       <= S_IDLE;
			xlate_req_q <= 1'b0;
			done_q      <= 1'b0;
			exc_valid_q <= 1'b0;
			exc_code_q  <= EXC_NONE;
			live        <= '0;
		end else begin
			xlate_req_q <= 1'b0;
			done_q      <= 1'b0;
			exc_valid_q <= 1'b0;
			live        <= {live[RAM_LATENCY-2:0], req & gnt & ~we};
			if (flush) begin
				state <= S_IDLE;
				live  <= '0;
			end else begin
				case (state)
					S_IDLE: begin
						if (accept) begin
							state       <= S_XLATE;
							xlate_req_q <= 1'b1;
						end
					end
					S_XLATE: begin
						if (xlate_ready) begin
							exc_code_q <= exc_n;
							if (exc_n != EXC_NONE) begin
								state       <= S_IDLE;
								done_q      <= 1'b1;
								exc_valid_q <= 1'b1;
							end else begin
								state <= S_BUS;
							end
						end
					end
					S_BUS: begin
						if (gnt) begin
							state  <= we ? S_IDLE : S_DATA;
							done_q <= we;
						end
					end
					S_DATA: begin
						if (ret_ok)
							state <= S_IDLE;
					end
					default: state <= S_IDLE;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			op_q         <= op;
			vaddr_q      <= base + {{16{offset[15]}}, offset};
			store_data_q <= store_data;
			rt_old_q     <= rt_old;
		end
		if (state == S_XLATE && xlate_ready)
			paddr_q <= paddr;
	end

endmodule

//--- addr_xlate.sv
`timescale 1ns/1ps

module addr_xlate import lsu_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        xlate_req,
	input  logic [31:0] vaddr,
	input  logic        is_store,
	output logic        xlate_ready,
	output logic [31:0] paddr,
	output logic        uncached,
	output logic        illegal,
	output logic        miss,
	output logic        read_only
);

	logic [31:0] paddr_n;
	logic        uncached_n;
	logic        illegal_n;
	logic        miss_n;
	logic        read_only_n;

	always_comb begin
		paddr_n     = vaddr;
		uncached_n  = 1'b0;
		illegal_n   = 1'b0;
		miss_n      = 1'b0;
		read_only_n = 1'b0;
		if (vaddr >= KSEG2_BASE) begin
			illegal_n = 1'b1;
		end else if (vaddr >= KSEG0_BASE) begin
			// unmapped windows drop the segment bits
			paddr_n    = {3'b000, vaddr[28:0]};
			uncached_n = (vaddr >= KSEG1_BASE);
		end else if (vaddr < USEG_LIMIT) begin
			// only a store can fault on the low window
			read_only_n = (vaddr < USEG_RO_LIMIT) & is_store;
		end else begin
			miss_n = 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			xlate_ready <= 1'b0;
		end else begin
			xlate_ready <= xlate_req;
		end
	end

	always_ff @(posedge clk) begin
		if (xlate_req) begin
			paddr     <= paddr_n;
			uncached  <= uncached_n;
			illegal   <= illegal_n;
			miss      <= miss_n;
			read_only <= read_only_n;
		end
	end

endmodule

//--- lsu_pkg.sv
package lsu_pkg;

	// loads sit below 8, stores from 8 up
	typedef enum logic [3:0] {
		LB  = 4'd0,
		LBU = 4'd1,
		LH  = 4'd2,
		LHU = 4'd3,
		LW  = 4'd4,
		LWL = 4'd5,
		LWR = 4'd6,
		SB  = 4'd8,
		SH  = 4'd9,
		SW  = 4'd10,
		SWL = 4'd11,
		SWR = 4'd12
	} mem_op_t;

	// cause register values
	typedef enum logic [4:0] {
		EXC_NONE = 5'd0,
		EXC_MOD  = 5'd1,
		EXC_TLBL = 5'd2,
		EXC_TLBS = 5'd3,
		EXC_ADEL = 5'd4,
		EXC_ADES = 5'd5
	} exc_code_t;

	// segment map
	localparam logic [31:0] KSEG0_BASE    = 32'h8000_0000;
	localparam logic [31:0] KSEG1_BASE    = 32'hA000_0000;
	localparam logic [31:0] KSEG2_BASE    = 32'hC000_0000;
	localparam logic [31:0] USEG_LIMIT    = 32'h0000_1000;
	localparam logic [31:0] USEG_RO_LIMIT = 32'h0000_0400;

	// data memory
	localparam int RAM_WORDS   = 1024;
	localparam int RAM_AW      = 10;
	localparam int RAM_LATENCY = 2;

endpackage
